// File: fetch_front.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/inst_predecode.sv
rtl/branch_predictor.sv
rtl/pc_reg.sv
rtl/fetch_front.sv
tests/fetch_front_props.sv
tests/fetch_front_tb.sv

// File: rtl/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module branch_predictor (
    input  logic               clk,
    input  logic               rst,
    // lookup address from fetch
    input  logic [`ADDR_W-1:0] pc,
    // training from execute
    input  logic               resolve_valid,
    input  logic [`ADDR_W-1:0] resolve_pc,
    input  logic               resolve_taken,
    output logic               counter_taken
);

    localparam int IDX_W = $clog2(`BHT_DEPTH);

    // counter encoding
    // 0 strong not-taken, 1 weak not-taken, 2 weak taken, 3 strong taken
    localparam logic [1:0] CNT_MIN     = 2'b00;
    localparam logic [1:0] CNT_WEAK_NT = 2'b01;
    localparam logic [1:0] CNT_MAX     = 2'b11;

    logic [1:0]       bht [`BHT_DEPTH];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [1:0]       wr_old;
    logic [1:0]       wr_new;

    ////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////

    // word address bits just above the byte offset
    assign rd_idx = pc[IDX_W+1:2];

    // msb of the counter is the taken guess
    assign counter_taken = bht[rd_idx][1];

    ////////////////////////////////////////////////////////////////////////
    // training
    ////////////////////////////////////////////////////////////////////////

    // saturating step toward the resolved direction
    function automatic logic [1:0] sat_step(
        input logic [1:0] cnt,
        input logic       up
    );
        logic [1:0] res;
        res = cnt;
        if (up) begin
            if (cnt != CNT_MAX) begin
                res = cnt + 2'd1;
            end
        end else begin
            if (cnt != CNT_MIN) begin
                res = cnt - 2'd1;
            end
        end
        return res;
    endfunction

    assign wr_idx = resolve_pc[IDX_W+1:2];
    assign wr_old = bht[wr_idx];
    assign wr_new = sat_step(wr_old, resolve_taken);

    // write lands at the clock edge
    // lookup in the same cycle still sees the old count
    always_ff @(posedge clk) begin
        if (rst) begin
            // all entries start weakly not-taken
            for (int i = 0; i < `BHT_DEPTH; i++) begin
                bht[i] <= CNT_WEAK_NT;
            end
        end else if (resolve_valid) begin
            bht[wr_idx] <= wr_new;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_front
    import fetch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    // word read at pc, same cycle
    input  logic [31:0]        inst,
    input  logic               pause,
    input  logic               exception_flush,
    input  logic [`ADDR_W-1:0] exception_new_pc,
    input  logic               is_interrupt,
    input  logic               branch_flush,
    input  logic [`ADDR_W-1:0] branch_actual_addr,
    // predictor training
    input  logic               resolve_valid,
    input  logic [`ADDR_W-1:0] resolve_pc,
    input  logic               resolve_taken,
    output logic [`ADDR_W-1:0] pc,
    output logic               inst_en,
    output logic [1:0]         is_exception,
    output exc_cause_t [1:0]   exception_cause
);

    logic               is_branch;
    logic               counter_taken;
    logic               pre_taken_or_not;
    logic [`ADDR_W-1:0] pre_branch_addr;

    ////////////////////////////////////////////////////////////////////////
    // predecode and prediction, both combinational on pc
    ////////////////////////////////////////////////////////////////////////

    inst_predecode i_predecode (
        .inst             (inst),
        .pc               (pc),
        .counter_taken    (counter_taken),
        .is_branch        (is_branch),
        .pre_taken_or_not (pre_taken_or_not),
        .pre_branch_addr  (pre_branch_addr)
    );

    branch_predictor i_predictor (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .resolve_valid (resolve_valid),
        .resolve_pc    (resolve_pc),
        .resolve_taken (resolve_taken),
        .counter_taken (counter_taken)
    );

    // pc register and next-address select
    pc_reg i_pc_reg (
        .clk                (clk),
        .rst                (rst),
        .is_branch          (is_branch),
        .pre_taken_or_not   (pre_taken_or_not),
        .pre_branch_addr    (pre_branch_addr),
        .branch_flush       (branch_flush),
        .branch_actual_addr (branch_actual_addr),
        .exception_flush    (exception_flush),
        .exception_new_pc   (exception_new_pc),
        .pause              (pause),
        .is_interrupt       (is_interrupt),
        .pc                 (pc),
        .inst_en            (inst_en),
        .is_exception       (is_exception),
        .exception_cause    (exception_cause)
    );

endmodule

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////
    // instruction word views
    ////////////////////////////////////////////////////////////////////////

    // one fetched word, two encodings sharing the opcode field
    typedef union packed {
        // B and BL
        // 26-bit offset stored low half first
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } fmt_i26;
        // BEQ, BNE, BLT, BGE, BLTU, BGEU
        // 16-bit offset plus the two compared registers
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_2ri16;
    } inst_word_u;

    ////////////////////////////////////////////////////////////////////////
    // exception causes seen at fetch
    ////////////////////////////////////////////////////////////////////////

    // codes come from the settings header
    typedef enum logic [5:0] {
        CAUSE_NOP  = `EXC_NOP,
        CAUSE_INT  = `EXC_INT,
        CAUSE_ADEF = `EXC_ADEF
    } exc_cause_t;

endpackage

`default_nettype wire

// File: rtl/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// instruction address width for pc, targets and redirects
`define ADDR_W 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// number of two-bit counters in the branch history table
// power of two, 8 to 64 are fine
`define BHT_DEPTH 16

////////////////////////////////////////////////////////////////////////////
// exception cause codes
////////////////////////////////////////////////////////////////////////////

// interrupt shares ecode 0 with no exception
// so it carries an extra subcode bit to keep the two apart
`define EXC_SUB_INT 6'h20
`define EXC_NOP 6'h00
`define EXC_INT (6'h00 | `EXC_SUB_INT)
`define EXC_ADEF 6'h08

`endif

// File: rtl/inst_predecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module inst_predecode
    import fetch_pkg::*;
(
    input  logic [31:0]        inst,
    input  logic [`ADDR_W-1:0] pc,
    // upper bit of the bht counter at pc
    input  logic               counter_taken,
    output logic               is_branch,
    output logic               pre_taken_or_not,
    output logic [`ADDR_W-1:0] pre_branch_addr
);

    // major opcodes of the direct branches
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    inst_word_u         word;
    logic [5:0]         opcode;
    logic               is_uncond;
    logic               is_cond;
    logic [25:0]        offs26;
    logic [`ADDR_W-1:0] imm_i26;
    logic [`ADDR_W-1:0] imm_2ri16;

    assign word   = inst;
    assign opcode = word.fmt_i26.opcode;

    // B/BL jump always
    assign is_uncond = (opcode == OP_B) || (opcode == OP_BL);
    // compare branches sit in one contiguous opcode run
    assign is_cond   = (opcode >= OP_BEQ) && (opcode <= OP_BGEU);
    assign is_branch = is_uncond || is_cond;

    ////////////////////////////////////////////////////////////////////////
    // target address
    ////////////////////////////////////////////////////////////////////////

    // high bits of the long offset live in the bottom of the word
    assign offs26 = {word.fmt_i26.offs_hi, word.fmt_i26.offs_lo};

    // word offsets, sign extended and scaled to bytes
    assign imm_i26   = {{(`ADDR_W-28){offs26[25]}}, offs26, 2'b00};
    assign imm_2ri16 = {{(`ADDR_W-18){word.fmt_2ri16.offs16[15]}},
                        word.fmt_2ri16.offs16, 2'b00};

    assign pre_branch_addr = pc + (is_uncond ? imm_i26 : imm_2ri16);

    // unconditional always taken, conditional follows the counter
    assign pre_taken_or_not = is_uncond || (is_cond && counter_taken);

endmodule

`default_nettype wire

// File: rtl/pc_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module pc_reg
    import fetch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    // predecode side
    input  logic               is_branch,
    input  logic               pre_taken_or_not,
    input  logic [`ADDR_W-1:0] pre_branch_addr,
    // execute side redirect
    input  logic               branch_flush,
    input  logic [`ADDR_W-1:0] branch_actual_addr,
    // commit side redirect
    input  logic               exception_flush,
    input  logic [`ADDR_W-1:0] exception_new_pc,
    input  logic               pause,
    input  logic               is_interrupt,
    output logic [`ADDR_W-1:0] pc,
    output logic               inst_en,
    // bit 1 interrupt, bit 0 adef
    output logic [1:0]         is_exception,
    output exc_cause_t [1:0]   exception_cause
);

    localparam logic [`ADDR_W-1:0] PC_STEP = 4;

    logic [`ADDR_W-1:0] next_pc;
    logic               pc_misaligned;

    // fetch enable goes high once reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_en <= 1'b0;
        end else begin
            inst_en <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // next fetch address
    ////////////////////////////////////////////////////////////////////////

    // exception beats pause, pause beats everything below it
    always_comb begin
        if (exception_flush) begin
            next_pc = exception_new_pc;
        end else if (pause) begin
            next_pc = pc;
        end else if (branch_flush) begin
            next_pc = branch_actual_addr;
        end else if (is_branch && pre_taken_or_not) begin
            next_pc = pre_branch_addr;
        end else begin
            next_pc = pc + PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // exception tags on the current fetch address
    assign pc_misaligned = (pc[1:0] != 2'b00);
    assign is_exception = {is_interrupt, pc_misaligned};
    assign exception_cause[1] = is_interrupt ? CAUSE_INT : CAUSE_NOP;
    assign exception_cause[0] = pc_misaligned ? CAUSE_ADEF : CAUSE_NOP;

endmodule

`default_nettype wire

// File: tests/fetch_front_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_front_props (
    input logic               clk,
    input logic               rst,
    input logic               pause,
    input logic               exception_flush,
    input logic [`ADDR_W-1:0] pc,
    input logic               inst_en
);

    // number of assertion failures so far
    int fail_cnt = 0;

    // fetch stays off while reset is applied
    a_en_low_in_reset: assert property (@(posedge clk) rst |=> !inst_en)
        else begin
            $error("inst_en high after a reset cycle");
            fail_cnt++;
        end

    // reset always lands on the boot address
    a_pc_after_reset: assert property (@(posedge clk) rst |=> pc == `RESET_PC)
        else begin
            $error("pc differs from reset address after reset");
            fail_cnt++;
        end

    // pause freezes fetch unless an exception redirects it
    a_pause_hold: assert property (@(posedge clk) disable iff (rst)
        (pause && !exception_flush) |=> pc == $past(pc))
        else begin
            $error("pc moved while paused without exception");
            fail_cnt++;
        end

endmodule

bind pc_reg fetch_front_props i_props (
    .clk             (clk),
    .rst             (rst),
    .pause           (pause),
    .exception_flush (exception_flush),
    .pc              (pc),
    .inst_en         (inst_en)
);

`default_nettype wire

// File: tests/fetch_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_front_tb
    import fetch_pkg::*;
();

    logic clk;
    logic rst;
    logic [31:0] inst;
    logic pause;
    logic exception_flush;
    logic [`ADDR_W-1:0] exception_new_pc;
    logic is_interrupt;
    logic branch_flush;
    logic [`ADDR_W-1:0] branch_actual_addr;
    logic resolve_valid;
    logic [`ADDR_W-1:0] resolve_pc;
    logic resolve_taken;
    logic [`ADDR_W-1:0] pc;
    logic inst_en;
    logic [1:0] is_exception;
    exc_cause_t [1:0] exception_cause;

    string lines[$];
    int val_errs = 0;
    int other_errs = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    fetch_front i_dut (.*);

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_pc(input string name, input logic [`ADDR_W-1:0] exp,
                            input logic [`ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s exp %h got %h", name, exp, act);
            val_errs++;
        end
    endtask

    // flag bit and its cause code together
    task automatic check_cause(input int idx, input logic exp_flag, input logic act_flag,
                               input exc_cause_t exp, input exc_cause_t act);
        if (act_flag !== exp_flag) begin
            $display("ERR is_exception[%0d] exp %h got %h", idx, exp_flag, act_flag);
            val_errs++;
        end
        if (act !== exp) begin
            $display("ERR exception_cause[%0d] exp %h got %h", idx, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s exp %h got %h", name, exp, act);
            val_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_patterns();
        int fd;
        string line;
        fd = $fopen("tests/fetch_patterns.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                // skip header comments and blank lines
                if ($fgets(line, fd) > 0 && line.len() > 2 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // two cycles of reset, released on a falling edge
    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_pc("pc", `RESET_PC, pc);
        check_bit("inst_en", 1'b0, inst_en);
        rst = 1'b0;
    endtask

    // one pattern line per cycle, starts and ends on a falling edge
    task automatic run_line(input int idx);
        int n;
        logic [`ADDR_W-1:0] exp_next;
        logic [1:0] exp_exc;
        logic [5:0] exp_c1;
        logic [5:0] exp_c0;
        n = $sscanf(lines[idx], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    inst, pause, exception_flush, exception_new_pc, is_interrupt,
                    branch_flush, branch_actual_addr, resolve_valid, resolve_pc,
                    resolve_taken, exp_next, exp_exc, exp_c1, exp_c0);
        if (n != 14) begin
            $display("pattern line %0d could not be parsed", idx);
            other_errs++;
        end else begin
            // tags settle well before the rising edge
            #2;
            check_cause(1, exp_exc[1], is_exception[1], exc_cause_t'(exp_c1),
                        exception_cause[1]);
            check_cause(0, exp_exc[0], is_exception[0], exc_cause_t'(exp_c0),
                        exception_cause[0]);
            // enable rises at the first edge out of reset
            if (idx > 0) begin
                check_bit("inst_en", 1'b1, inst_en);
            end
            @(negedge clk);
            check_pc("pc", exp_next, pc);
        end
    endtask

    task automatic finish_run();
        int prop_errs;
        prop_errs = i_dut.i_pc_reg.i_props.fail_cnt;
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 val_errs, other_errs, prop_errs);
        if (val_errs + other_errs + prop_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    initial begin
        rst = 1'b1;
        inst = 32'h0;
        pause = 1'b0;
        exception_flush = 1'b0;
        exception_new_pc = '0;
        is_interrupt = 1'b0;
        branch_flush = 1'b0;
        branch_actual_addr = '0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_taken = 1'b0;
        load_patterns();
        if (lines.size() == 0) begin
            $display("no stimulus read from tests/fetch_patterns.txt");
            other_errs++;
        end else begin
            cycle_limit = lines.size() + 20;
            apply_reset();
            foreach (lines[i]) begin
                run_line(i);
            end
        end
        finish_run();
    end

    // watchdog on clock cycles
    initial begin
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles without finishing", cycle_cnt);
        other_errs++;
        finish_run();
    end

endmodule

`default_nettype wire

// File: tests/fetch_patterns.txt
# inst pause exc_flush exc_new_pc is_int br_flush br_addr res_valid res_pc res_taken
# exp_next_pc exp_is_exception exp_cause1 exp_cause0, all hex, tags for the pc of the cycle
02800000 0 0 00000000 0 0 00000000 0 00000000 0 00000004 0 00 00
02800000 0 0 00000000 0 0 00000000 0 00000000 0 00000008 0 00 00
02800000 1 0 00000000 0 0 00000000 0 00000000 0 00000008 0 00 00
02800000 1 0 00000000 0 0 00000000 0 00000000 0 00000008 0 00 00
02800000 1 1 00000100 0 0 00000000 0 00000000 0 00000100 0 00 00
50004000 0 0 00000000 0 0 00000000 0 00000000 0 00000140 0 00 00
58002000 0 0 00000000 0 0 00000000 1 00000140 1 00000144 0 00 00
02800000 0 0 00000000 0 0 00000000 1 00000140 1 00000148 0 00 00
02800000 0 0 00000000 0 1 00000140 0 00000000 0 00000140 0 00 00
58002000 0 0 00000000 0 0 00000000 0 00000000 0 00000160 0 00 00
5000a000 0 0 00000000 0 1 00000300 0 00000000 0 00000300 0 00 00
02800000 0 1 00000500 0 1 00000400 0 00000000 0 00000500 0 00 00
02800000 0 1 00000602 0 0 00000000 0 00000000 0 00000602 0 00 00
02800000 0 1 00000700 0 0 00000000 0 00000000 0 00000700 1 00 08
02800000 0 0 00000000 1 0 00000000 0 00000000 0 00000704 2 20 00
02800000 0 0 00000000 0 0 00000000 0 00000000 0 00000708 0 00 00
53fffbff 0 0 00000000 0 0 00000000 0 00000000 0 00000700 0 00 00
02800000 1 0 00000000 0 0 00000000 0 00000000 0 00000700 0 00 00
02800000 0 0 00000000 0 0 00000000 0 00000000 0 00000704 0 00 00
